//--- logic/gw_link_pkg.sv
`default_nettype none

package gw_link_pkg;

  localparam int TRACE_W      = 16;
  localparam int PAYLOAD_W    = 8;
  localparam int TRACE_ADDR_W = 3;

  // Count field of a wait entry fills all bits below the opcode
  localparam int WAIT_W = TRACE_W - 2;

  // Configuration bits within a tag payload
  localparam int CFG_TX_EN_BIT  = 0;
  localparam int CFG_INVERT_BIT = 1;

  typedef enum logic [1:0] {
    OP_SEND = 2'd0,
    OP_WAIT = 2'd1,
    OP_DONE = 2'd2,
    OP_NOP  = 2'd3
  } trace_op_e;

  // Send view
  typedef struct packed {
    trace_op_e                      op;
    logic [TRACE_W-2-PAYLOAD_W-1:0] rsvd;
    logic [PAYLOAD_W-1:0]           payload;
  } trace_send_s;

  // Wait view
  typedef struct packed {
    trace_op_e         op;
    logic [WAIT_W-1:0] cycles;
  } trace_wait_s;

  // One ROM word, opcode in the same upper bits in both views
  typedef union packed {
    trace_send_s send;
    trace_wait_s delay;
  } trace_entry_u;

endpackage

`default_nettype wire

//--- logic/tag_trace_rom.sv
`timescale 1ns/1ps
`default_nettype none

module tag_trace_rom
(
  input  wire logic [gw_link_pkg::TRACE_ADDR_W-1:0] addr_i,
  output      gw_link_pkg::trace_entry_u            data_o
);
  import gw_link_pkg::*;

  localparam logic [PAYLOAD_W-1:0] CFG_HOLD = PAYLOAD_W'(1 << CFG_INVERT_BIT);
  localparam logic [PAYLOAD_W-1:0] CFG_RUN  =
    PAYLOAD_W'((1 << CFG_INVERT_BIT) | (1 << CFG_TX_EN_BIT));
  localparam logic [WAIT_W-1:0]    SETTLE_CYCLES = WAIT_W'(20);

  always_comb
  begin
    data_o = '0;
    case (addr_i)
      TRACE_ADDR_W'(0):
      begin
        // Transmitter off, polarity inverted
        data_o.send.op      = OP_SEND;
        data_o.send.payload = CFG_HOLD;
      end
      TRACE_ADDR_W'(1):
      begin
        data_o.delay.op     = OP_WAIT;
        data_o.delay.cycles = SETTLE_CYCLES;
      end
      TRACE_ADDR_W'(2):
      begin
        data_o.send.op      = OP_SEND;
        data_o.send.payload = CFG_RUN;
      end
      TRACE_ADDR_W'(3):
        data_o.send.op = OP_DONE;
      default:
        data_o.send.op = OP_NOP;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/tag_trace_replay.sv
`timescale 1ns/1ps
`default_nettype none

module tag_trace_replay
(
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  output      logic [gw_link_pkg::TRACE_ADDR_W-1:0] rom_addr_o,
  input  wire gw_link_pkg::trace_entry_u            rom_data_i,
  output      logic                                 tag_en_o,
  output      logic                                 tag_data_o,
  output      logic                                 done_o
);
  import gw_link_pkg::*;

  localparam logic [1:0] ST_FETCH = 2'd0;
  localparam logic [1:0] ST_SEND  = 2'd1;
  localparam logic [1:0] ST_WAIT  = 2'd2;
  localparam logic [1:0] ST_DONE  = 2'd3;

  localparam int BIT_CNT_W = $clog2(PAYLOAD_W);

  logic [1:0]           state_r;
  logic [BIT_CNT_W-1:0] bit_cnt_r;
  logic [WAIT_W-1:0]    wait_cnt_r;
  logic [PAYLOAD_W-1:0] shift_r;

  //////////////////////////////////////////////////
  // Entry FSM

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r    <= ST_FETCH;
      rom_addr_o <= '0;
      bit_cnt_r  <= '0;
      wait_cnt_r <= '0;
      tag_en_o   <= 1'b0;
      tag_data_o <= 1'b0;
      done_o     <= 1'b0;
    end
    else
    begin
      case (state_r)
        ST_FETCH:
        begin
          tag_en_o   <= 1'b0;
          tag_data_o <= 1'b0;
          case (rom_data_i.send.op)
            OP_SEND:
            begin
              // Start bit this cycle, payload follows
              tag_en_o   <= 1'b1;
              tag_data_o <= 1'b1;
              bit_cnt_r  <= BIT_CNT_W'(PAYLOAD_W - 1);
              state_r    <= ST_SEND;
            end
            OP_WAIT:
            begin
              wait_cnt_r <= rom_data_i.delay.cycles;
              state_r    <= ST_WAIT;
            end
            OP_DONE:
            begin
              done_o  <= 1'b1;
              state_r <= ST_DONE;
            end
            default:
              rom_addr_o <= rom_addr_o + TRACE_ADDR_W'(1);
          endcase
        end
        ST_SEND:
        begin
          tag_data_o <= shift_r[0];
          bit_cnt_r  <= bit_cnt_r - BIT_CNT_W'(1);
          if (bit_cnt_r == '0)
          begin
            state_r    <= ST_FETCH;
            rom_addr_o <= rom_addr_o + TRACE_ADDR_W'(1);
          end
        end
        ST_WAIT:
        begin
          wait_cnt_r <= wait_cnt_r - WAIT_W'(1);
          // A zero count still costs one cycle
          if (wait_cnt_r <= WAIT_W'(1))
          begin
            state_r    <= ST_FETCH;
            rom_addr_o <= rom_addr_o + TRACE_ADDR_W'(1);
          end
        end
        default:
          done_o <= 1'b1;
      endcase
    end
  end

  // Payload bits, LSB first
  always_ff @(posedge clk_i)
  begin
    if (state_r == ST_FETCH)
      shift_r <= rom_data_i.send.payload;
    else if (state_r == ST_SEND)
      shift_r <= shift_r >> 1;
  end

endmodule

`default_nettype wire

//--- logic/tag_client.sv
`timescale 1ns/1ps
`default_nettype none

module tag_client
(
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic tag_en_i,
  input  wire logic tag_data_i,
  output      logic cfg_tx_en_o,
  output      logic cfg_invert_o
);
  import gw_link_pkg::*;

  localparam int BIT_CNT_W = $clog2(PAYLOAD_W);

  logic                 busy_r;
  logic [BIT_CNT_W-1:0] bit_cnt_r;
  logic [PAYLOAD_W-2:0] shift_r;
  logic [PAYLOAD_W-1:0] payload;

  // Last bit joins the ones already shifted in
  assign payload = {tag_data_i, shift_r};

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      busy_r       <= 1'b0;
      bit_cnt_r    <= '0;
      cfg_tx_en_o  <= 1'b0;
      cfg_invert_o <= 1'b0;
    end
    else if (tag_en_i)
    begin
      if (!busy_r)
      begin
        busy_r    <= tag_data_i;
        bit_cnt_r <= '0;
      end
      else
      begin
        bit_cnt_r <= bit_cnt_r + BIT_CNT_W'(1);
        if (bit_cnt_r == BIT_CNT_W'(PAYLOAD_W - 1))
        begin
          busy_r       <= 1'b0;
          cfg_tx_en_o  <= payload[CFG_TX_EN_BIT];
          cfg_invert_o <= payload[CFG_INVERT_BIT];
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (tag_en_i && busy_r)
      shift_r <= {tag_data_i, shift_r[PAYLOAD_W-2:1]};
  end

endmodule

`default_nettype wire

//--- logic/link_rx.sv
`timescale 1ns/1ps
`default_nettype none

module link_rx
#(
  parameter int DATA_W              = 16,
  parameter int LG_FIFO_DEPTH       = 3,
  parameter int LG_TOKEN_DECIMATION = 1
)
(
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              link_v_i,
  input  wire logic [DATA_W-1:0] link_data_i,
  output      logic              link_tkn_o,
  output      logic              deq_v_o,
  output      logic [DATA_W-1:0] deq_data_o,
  input  wire logic              deq_yumi_i
);

  localparam int DEPTH         = 1 << LG_FIFO_DEPTH;
  localparam int PTR_W         = LG_FIFO_DEPTH + 1;
  localparam int TKN_CNT_W     = LG_TOKEN_DECIMATION + 1;
  localparam int TOKEN_CREDITS = 1 << LG_TOKEN_DECIMATION;

  logic [DATA_W-1:0]    mem_r [DEPTH];
  // Top pointer bit tells full from empty
  logic [PTR_W-1:0]     wr_ptr_r;
  logic [PTR_W-1:0]     rd_ptr_r;
  logic [TKN_CNT_W-1:0] tkn_cnt_r;

  assign deq_v_o    = (wr_ptr_r != rd_ptr_r);
  assign deq_data_o = mem_r[rd_ptr_r[LG_FIFO_DEPTH-1:0]];

  always_ff @(posedge clk_i)
  begin
    if (link_v_i)
      mem_r[wr_ptr_r[LG_FIFO_DEPTH-1:0]] <= link_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r   <= '0;
      rd_ptr_r   <= '0;
      tkn_cnt_r  <= '0;
      link_tkn_o <= 1'b0;
    end
    else
    begin
      link_tkn_o <= 1'b0;
      if (link_v_i)
        wr_ptr_r <= wr_ptr_r + PTR_W'(1);
      if (deq_yumi_i)
      begin
        rd_ptr_r <= rd_ptr_r + PTR_W'(1);
        // One token per group of freed slots
        if (tkn_cnt_r == TKN_CNT_W'(TOKEN_CREDITS - 1))
        begin
          tkn_cnt_r  <= '0;
          link_tkn_o <= 1'b1;
        end
        else
          tkn_cnt_r <= tkn_cnt_r + TKN_CNT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/link_tx.sv
`timescale 1ns/1ps
`default_nettype none

module link_tx
#(
  parameter int DATA_W              = 16,
  parameter int LG_TOKEN_DECIMATION = 1,
  parameter int REMOTE_CREDITS      = 8
)
(
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              cfg_tx_en_i,
  input  wire logic              cfg_invert_i,
  input  wire logic              deq_v_i,
  input  wire logic [DATA_W-1:0] deq_data_i,
  output      logic              deq_yumi_o,
  output      logic              link_v_o,
  output      logic [DATA_W-1:0] link_data_o,
  input  wire logic              link_tkn_i
);

  localparam int TOKEN_CREDITS = 1 << LG_TOKEN_DECIMATION;
  localparam int CREDIT_W      = $clog2(REMOTE_CREDITS + 1);

  logic [CREDIT_W-1:0] credit_r;
  logic [CREDIT_W-1:0] credit_add;
  logic [CREDIT_W-1:0] credit_sub;

  // Take a word only with a credit in hand
  assign deq_yumi_o = cfg_tx_en_i && deq_v_i && (credit_r != '0);

  assign credit_add = link_tkn_i ? CREDIT_W'(TOKEN_CREDITS) : '0;
  assign credit_sub = deq_yumi_o ? CREDIT_W'(1) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      credit_r <= CREDIT_W'(REMOTE_CREDITS);
      link_v_o <= 1'b0;
    end
    else
    begin
      credit_r <= credit_r + credit_add - credit_sub;
      link_v_o <= deq_yumi_o;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (deq_yumi_o)
      link_data_o <= deq_data_i ^ {DATA_W{cfg_invert_i}};
  end

endmodule

`default_nettype wire

//--- logic/gw_link.sv
`timescale 1ns/1ps
`default_nettype none

module gw_link
#(
  parameter int DATA_W              = 16,
  parameter int LG_FIFO_DEPTH       = 3,
  parameter int LG_TOKEN_DECIMATION = 1,
  parameter int REMOTE_CREDITS      = 8
)
(
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              link_v_i,
  input  wire logic [DATA_W-1:0] link_data_i,
  output      logic              link_tkn_o,
  output      logic              link_v_o,
  output      logic [DATA_W-1:0] link_data_o,
  input  wire logic              link_tkn_i,
  output      logic              done_o
);
  import gw_link_pkg::*;

  logic [TRACE_ADDR_W-1:0] rom_addr;
  trace_entry_u            rom_data;
  logic                    tag_en;
  logic                    tag_data;
  logic                    cfg_tx_en;
  logic                    cfg_invert;
  logic                    deq_v;
  logic [DATA_W-1:0]       deq_data;
  logic                    deq_yumi;

  //////////////////////////////////////////////////
  // Configuration path

  tag_trace_rom i_tag_trace_rom
  (
    .addr_i (rom_addr),
    .data_o (rom_data)
  );

  tag_trace_replay i_tag_trace_replay
  (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rom_addr_o (rom_addr),
    .rom_data_i (rom_data),
    .tag_en_o   (tag_en),
    .tag_data_o (tag_data),
    .done_o     (done_o)
  );

  tag_client i_tag_client
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tag_en_i     (tag_en),
    .tag_data_i   (tag_data),
    .cfg_tx_en_o  (cfg_tx_en),
    .cfg_invert_o (cfg_invert)
  );

  //////////////////////////////////////////////////
  // Link

  link_rx #(
    .DATA_W              (DATA_W),
    .LG_FIFO_DEPTH       (LG_FIFO_DEPTH),
    .LG_TOKEN_DECIMATION (LG_TOKEN_DECIMATION)
  ) i_link_rx (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .link_v_i    (link_v_i),
    .link_data_i (link_data_i),
    .link_tkn_o  (link_tkn_o),
    .deq_v_o     (deq_v),
    .deq_data_o  (deq_data),
    .deq_yumi_i  (deq_yumi)
  );

  link_tx #(
    .DATA_W              (DATA_W),
    .LG_TOKEN_DECIMATION (LG_TOKEN_DECIMATION),
    .REMOTE_CREDITS      (REMOTE_CREDITS)
  ) i_link_tx (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_tx_en_i  (cfg_tx_en),
    .cfg_invert_i (cfg_invert),
    .deq_v_i      (deq_v),
    .deq_data_i   (deq_data),
    .deq_yumi_o   (deq_yumi),
    .link_v_o     (link_v_o),
    .link_data_o  (link_data_o),
    .link_tkn_i   (link_tkn_i)
  );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
  parameter int HALF_PERIOD_NS = 2
)
(
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
  end

  always #(HALF_PERIOD_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- bench/gw_link_props.sv
`timescale 1ns/1ps
`default_nettype none

module gw_link_props
#(
  parameter int LG_FIFO_DEPTH       = 3,
  parameter int LG_TOKEN_DECIMATION = 1,
  parameter int REMOTE_CREDITS      = 8
)
(
  input wire logic clk_i,
  input wire logic rst_n_i,
  input wire logic link_v_i,
  input wire logic link_tkn_o,
  input wire logic link_v_o,
  input wire logic link_tkn_i,
  input wire logic done_o,
  input wire logic deq_v_i,
  input wire logic deq_yumi_i
);

  localparam int DEPTH         = 1 << LG_FIFO_DEPTH;
  localparam int TOKEN_CREDITS = 1 << LG_TOKEN_DECIMATION;

  int fill_r;
  // Words taken by the transmitter and not yet paid back by tokens
  int out_r;
  int word_cnt_r;
  int tkn_cnt_r;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      fill_r     <= 0;
      out_r      <= 0;
      word_cnt_r <= 0;
      tkn_cnt_r  <= 0;
    end
    else
    begin
      fill_r     <= fill_r + (link_v_i ? 1 : 0) - (deq_yumi_i ? 1 : 0);
      out_r      <= out_r + (deq_yumi_i ? 1 : 0) - (link_tkn_i ? TOKEN_CREDITS : 0);
      word_cnt_r <= word_cnt_r + (link_v_o ? 1 : 0);
      tkn_cnt_r  <= tkn_cnt_r + (link_tkn_o ? 1 : 0);
    end
  end

  //////////////////////////////////////////////////
  // Reset and configuration order

  reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (!link_v_o && !link_tkn_o && !done_o))
    else $error("link outputs or done active right after reset");

  tx_after_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_v_o |-> done_o)
    else $error("word transmitted before the trace finished");

  done_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |=> done_o)
    else $error("done dropped after rising");

  //////////////////////////////////////////////////
  // Credit flow

  no_fifo_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_v_i |-> (fill_r < DEPTH))
    else $error("sender wrote into a full receive FIFO");

  token_rate: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tkn_cnt_r == (word_cnt_r >> LG_TOKEN_DECIMATION))
    else $error("token count does not match delivered words");

  credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_r >= 0) && (out_r <= REMOTE_CREDITS))
    else $error("outstanding words outside the remote credit range");

  stall_at_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_r == REMOTE_CREDITS) |=> !link_v_o)
    else $error("word sent with no credit left");

  // Returned credits restart a stalled transmitter
  resume_on_token: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_r == REMOTE_CREDITS && link_tkn_i && deq_v_i) |=> deq_yumi_i)
    else $error("transmitter did not resume after a token");

endmodule

bind gw_link gw_link_props #(
  .LG_FIFO_DEPTH       (LG_FIFO_DEPTH),
  .LG_TOKEN_DECIMATION (LG_TOKEN_DECIMATION),
  .REMOTE_CREDITS      (REMOTE_CREDITS)
) i_gw_link_props (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .link_v_i   (link_v_i),
  .link_tkn_o (link_tkn_o),
  .link_v_o   (link_v_o),
  .link_tkn_i (link_tkn_i),
  .done_o     (done_o),
  .deq_v_i    (deq_v),
  .deq_yumi_i (deq_yumi)
);

`default_nettype wire

//--- bench/gw_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gw_link_tb;

  localparam int DATA_W              = 16;
  localparam int LG_FIFO_DEPTH       = 3;
  localparam int LG_TOKEN_DECIMATION = 1;
  localparam int REMOTE_CREDITS      = 8;

  localparam int FIFO_CREDITS   = 1 << LG_FIFO_DEPTH;
  localparam int TOKEN_CREDITS  = 1 << LG_TOKEN_DECIMATION;
  localparam int NUM_WORDS      = 40;
  localparam int PRE_DONE_WORDS = 8;
  // Two send entries, one wait entry and some fetch cycles
  localparam int TRACE_CYCLES   = 2 * (1 + 8) + 20 + 8;
  localparam int TIMEOUT_CYCLES = NUM_WORDS * 4 + TRACE_CYCLES + 200;

  logic              clk_i;
  logic              rst_n_i;
  logic              link_v_i;
  logic [DATA_W-1:0] link_data_i;
  logic              link_tkn_o;
  logic              link_v_o;
  logic [DATA_W-1:0] link_data_o;
  logic              link_tkn_i;
  logic              done_o;

  logic [15:0]       lfsr_r;
  logic [DATA_W-1:0] sent_q [$];
  int                sender_credit;
  int                outstanding;
  int                sent_cnt;
  int                recv_cnt;
  int                cycle_cnt = 0;
  logic              done_seen;
  // Tokens held back until the first full credit stall
  logic              tokens_on;

  tb_clock i_tb_clock
  (
    .clk_o (clk_i)
  );

  gw_link #(
    .DATA_W              (DATA_W),
    .LG_FIFO_DEPTH       (LG_FIFO_DEPTH),
    .LG_TOKEN_DECIMATION (LG_TOKEN_DECIMATION),
    .REMOTE_CREDITS      (REMOTE_CREDITS)
  ) i_gw_link (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .link_v_i    (link_v_i),
    .link_data_i (link_data_i),
    .link_tkn_o  (link_tkn_o),
    .link_v_o    (link_v_o),
    .link_data_o (link_data_o),
    .link_tkn_i  (link_tkn_i),
    .done_o      (done_o)
  );

  //////////////////////////////////////////////////
  // Helpers

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic report_error(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_outputs();
    logic [DATA_W-1:0] expected;
    if (done_o && !done_seen)
    begin
      done_seen = 1'b1;
      assert (sent_cnt == PRE_DONE_WORDS)
      else report_error($sformatf("FAIL %0t: %0d words sent before done, expected %0d",
                                  $time, sent_cnt, PRE_DONE_WORDS));
    end
    if (link_tkn_o)
      sender_credit += TOKEN_CREDITS;
    if (link_v_o)
    begin
      assert (sent_q.size() > 0)
      else report_error($sformatf("FAIL %0t: output word with no word sent", $time));
      expected = ~sent_q.pop_front();
      assert (link_data_o == expected)
      else report_error($sformatf("FAIL %0t: word %0d is %h, expected %h",
                                  $time, recv_cnt, link_data_o, expected));
      recv_cnt++;
      outstanding++;
      if (outstanding == REMOTE_CREDITS)
        tokens_on = 1'b1;
    end
    assert (sender_credit <= FIFO_CREDITS)
    else report_error($sformatf("FAIL %0t: sender credit %0d above %0d",
                                $time, sender_credit, FIFO_CREDITS));
  endtask

  task automatic drive_inputs();
    logic [DATA_W-1:0] word;
    logic              withhold;
    int                i;
    link_v_i   = 1'b0;
    link_tkn_i = 1'b0;
    if (sent_cnt < NUM_WORDS && sender_credit > 0)
    begin
      for (i = 0; i < DATA_W; i++)
      begin
        lfsr_r  = lfsr_next(lfsr_r);
        word[i] = lfsr_r[0];
      end
      link_v_i    = 1'b1;
      link_data_i = word;
      sent_q.push_back(word);
      sent_cnt++;
      sender_credit--;
    end
    lfsr_r   = lfsr_next(lfsr_r);
    withhold = lfsr_r[0];
    if (tokens_on && !withhold && outstanding >= TOKEN_CREDITS)
    begin
      link_tkn_i = 1'b1;
      outstanding -= TOKEN_CREDITS;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus

  initial
  begin
    rst_n_i       = 1'b0;
    link_v_i      = 1'b0;
    link_data_i   = '0;
    link_tkn_i    = 1'b0;
    lfsr_r        = 16'd32;
    sender_credit = FIFO_CREDITS;
    outstanding   = 0;
    sent_cnt      = 0;
    recv_cnt      = 0;
    done_seen     = 1'b0;
    tokens_on     = 1'b0;

    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    while (recv_cnt < NUM_WORDS)
    begin
      @(posedge clk_i);
      #1;
      check_outputs();
      drive_inputs();
    end

    // Drained FIFO hands every sender credit back
    if (sender_credit == FIFO_CREDITS)
    begin
      $display("Testbench passed");
      $finish;
    end
    else
      report_error($sformatf("FAIL %0t: sender credit %0d at the end, expected %0d",
                             $time, sender_credit, FIFO_CREDITS));
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      report_error($sformatf("Timeout after %0d cycles, not all words came through",
                             TIMEOUT_CYCLES));
  end

endmodule

`default_nettype wire

//--- gw_link.f
logic/gw_link_pkg.sv
logic/tag_trace_rom.sv
logic/tag_trace_replay.sv
logic/tag_client.sv
logic/link_rx.sv
logic/link_tx.sv
logic/gw_link.sv
bench/tb_clock.sv
bench/gw_link_props.sv
bench/gw_link_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the gw_link testbench with Verilator.
# The exit status is the simulator's own, nonzero on any failure.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f gw_link.f --top-module gw_link_tb -o gw_link_sim

./obj_dir/gw_link_sim
